//--- rtl/rv_pkg.sv
package rv_pkg;

    parameter int unsigned xlen = 32;

    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_i_type = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_r_type = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        st_fetch,
        st_decode,
        st_mem_addr,
        st_mem_read,
        st_mem_write,
        st_mem_wb,
        st_exec_r,
        st_exec_i,
        st_alu_wb,
        st_branch,
        st_exec_jal,
        st_exec_jalr,
        st_jalr_pc,
        st_exec_lui,
        st_exec_auipc,
        st_error
    } state_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll,
        alu_srl, alu_sra, alu_slt, alu_sltu, alu_none
    } alu_op_e;

    typedef enum logic [1:0] {src_a_pc, src_a_old_pc, src_a_reg1, src_a_zero} alu_src_a_e;

    typedef enum logic [1:0] {src_b_four, src_b_imm, src_b_reg2, src_b_zero} alu_src_b_e;

    typedef enum logic [2:0] {
        imm_i, imm_i_shift, imm_s, imm_b, imm_j, imm_u, imm_none
    } imm_src_e;

    // encodings follow the load/store funct3 field
    typedef enum logic [2:0] {
        dt_byte  = 3'b000,
        dt_half  = 3'b001,
        dt_word  = 3'b010,
        dt_ubyte = 3'b100,
        dt_uhalf = 3'b101,
        dt_none  = 3'b111
    } mem_dt_e;

    typedef enum logic [1:0] {res_alu_out, res_load, res_imm} res_src_e;

    typedef enum logic [1:0] {wd_result, wd_link} rf_wd_src_e;

    typedef struct packed {
        logic neg;
        logic zero;
        logic carry;    // set when a subtraction does not borrow
        logic overflow;
    } alu_flags_t;

endpackage

//--- rtl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  alu_op_e         op,
    output logic [xlen-1:0] y,
    output alu_flags_t      flags
);
    logic            use_sub;
    logic [xlen-1:0] b_in;
    logic [xlen-1:0] sum;
    logic            carry;
    logic            overflow;

    // subtract as a + ~b + 1
    assign use_sub  = (op == alu_sub) || (op == alu_slt) || (op == alu_sltu);
    assign b_in     = use_sub ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, b_in} + {{xlen{1'b0}}, use_sub};
    assign overflow = (a[xlen-1] == b_in[xlen-1]) && (sum[xlen-1] != a[xlen-1]);

    always_comb begin
        case (op)
            alu_add,
            alu_sub:  y = sum;
            alu_and:  y = a & b;
            alu_or:   y = a | b;
            alu_xor:  y = a ^ b;
            alu_sll:  y = a << b[4:0];
            alu_srl:  y = a >> b[4:0];
            alu_sra:  y = $signed(a) >>> b[4:0];
            alu_slt:  y = {{(xlen-1){1'b0}}, sum[xlen-1] ^ overflow};
            alu_sltu: y = {{(xlen-1){1'b0}}, ~carry}; // borrow means below
            default:  y = '0;
        endcase
    end

    assign flags.neg      = y[xlen-1];
    assign flags.zero     = (y == '0);
    assign flags.carry    = carry;
    assign flags.overflow = overflow;

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      ra1,
    input  logic [4:0]      ra2,
    input  logic [4:0]      wa,
    input  logic            we,
    input  logic [xlen-1:0] wd,
    output logic [xlen-1:0] rd1,
    output logic [xlen-1:0] rd2
);
    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin // x0 stays zero
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

//--- rtl/rv_imm_ext.sv
`timescale 1ns/1ps

module rv_imm_ext import rv_pkg::*; (
    input  logic [31:0]     instr,
    input  imm_src_e        imm_src,
    output logic [xlen-1:0] imm
);
    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_src)
            imm_i:       imm = {{20{sign}}, instr[31:20]};
            imm_i_shift: imm = {27'd0, instr[24:20]}; // shamt only
            imm_s:       imm = {{20{sign}}, instr[31:25], instr[11:7]};
            imm_b:       imm = {{19{sign}}, sign, instr[7], instr[30:25],
                                instr[11:8], 1'b0};
            imm_j:       imm = {{11{sign}}, sign, instr[19:12], instr[20],
                                instr[30:21], 1'b0};
            imm_u:       imm = {instr[31:12], 12'd0};
            default:     imm = '0;
        endcase
    end

endmodule

//--- rtl/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
    input  logic [1:0]      addr_lo,
    input  mem_dt_e         dt,
    input  logic [xlen-1:0] store_data,
    input  logic [xlen-1:0] rdata,
    output logic [xlen-1:0] wdata,
    output logic [3:0]      be,
    output logic [xlen-1:0] load_data
);
    logic [xlen-1:0] lane;

    // stores replicate into every lane, be picks the one that lands
    always_comb begin
        case (dt)
            dt_byte, dt_ubyte: begin
                wdata = {4{store_data[7:0]}};
                be    = 4'b0001 << addr_lo;
            end
            dt_half, dt_uhalf: begin
                wdata = {2{store_data[15:0]}};
                be    = addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            dt_word: begin
                wdata = store_data;
                be    = 4'b1111;
            end
            default: begin
                wdata = store_data;
                be    = 4'b0000;
            end
        endcase
    end

    assign lane = rdata >> {addr_lo, 3'b000}; // addressed byte to bit 0

    always_comb begin
        case (dt)
            dt_byte:  load_data = {{24{lane[7]}}, lane[7:0]};
            dt_ubyte: load_data = {24'd0, lane[7:0]};
            dt_half:  load_data = {{16{lane[15]}}, lane[15:0]};
            dt_uhalf: load_data = {16'd0, lane[15:0]};
            default:  load_data = rdata;
        endcase
    end

endmodule

//--- rtl/rv_controller.sv
`timescale 1ns/1ps

module rv_controller import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instr,
    input  alu_flags_t  alu_flags,
    output logic        rf_we,
    output logic        mem_we,
    output logic        ir_en,
    output logic        pc_en,
    output logic        old_pc_en,
    output logic        addr_src,
    output logic        data_en,
    output logic        halted,
    output alu_src_a_e  alu_src_a,
    output alu_src_b_e  alu_src_b,
    output alu_op_e     alu_op,
    output imm_src_e    imm_src,
    output mem_dt_e     dt,
    output res_src_e    res_src,
    output rf_wd_src_e  rf_wd_src
);
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_5;
    state_e     state;
    state_e     decode_ns;
    alu_op_e    alu_dec;
    mem_dt_e    mem_dt;
    logic       take_branch;

    assign opcode   = opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];
    assign halted   = (state == st_error);

    always_comb begin
        case (opcode)
            op_r_type: decode_ns = st_exec_r;
            op_i_type: decode_ns = st_exec_i;
            op_load:   decode_ns = st_mem_addr;
            op_store:  decode_ns = st_mem_addr;
            op_branch: decode_ns = st_branch;
            op_jal:    decode_ns = st_exec_jal;
            op_jalr:   decode_ns = st_exec_jalr;
            op_lui:    decode_ns = st_exec_lui;
            op_auipc:  decode_ns = st_exec_auipc;
            default:   decode_ns = st_error;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_fetch;
        end else begin
            case (state)
                st_fetch:     state <= st_decode;
                st_decode:    state <= decode_ns;
                st_mem_addr:  state <= (opcode == op_load) ? st_mem_read : st_mem_write;
                st_mem_read:  state <= st_mem_wb;
                st_exec_r:    state <= st_alu_wb;
                st_exec_i:    state <= st_alu_wb;
                st_exec_jalr: state <= st_jalr_pc;
                st_error:     state <= st_error; // stays until reset
                default:      state <= st_fetch;
            endcase
        end
    end

    always_comb begin
        case (funct3)
            3'b000:  alu_dec = (opcode == op_r_type && funct7_5) ? alu_sub : alu_add;
            3'b001:  alu_dec = alu_sll;
            3'b010:  alu_dec = alu_slt;
            3'b011:  alu_dec = alu_sltu;
            3'b100:  alu_dec = alu_xor;
            3'b101:  alu_dec = funct7_5 ? alu_sra : alu_srl;
            3'b110:  alu_dec = alu_or;
            default: alu_dec = alu_and;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  take_branch = alu_flags.zero;                          // beq
            3'b001:  take_branch = !alu_flags.zero;                         // bne
            3'b100:  take_branch = alu_flags.neg ^ alu_flags.overflow;      // blt
            3'b101:  take_branch = !(alu_flags.neg ^ alu_flags.overflow);   // bge
            3'b110:  take_branch = !alu_flags.carry;                        // bltu
            3'b111:  take_branch = alu_flags.carry;                         // bgeu
            default: take_branch = 1'b0;
        endcase
    end

    assign mem_dt = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) ?
                    mem_dt_e'(funct3) : dt_none;

    always_comb begin
        rf_we     = 1'b0;
        mem_we    = 1'b0;
        ir_en     = 1'b0;
        pc_en     = 1'b0;
        old_pc_en = 1'b0;
        addr_src  = 1'b0;
        data_en   = 1'b0;
        alu_src_a = src_a_zero;
        alu_src_b = src_b_zero;
        alu_op    = alu_none;
        imm_src   = imm_none;
        dt        = dt_none;
        res_src   = res_alu_out;
        rf_wd_src = wd_result;
        case (state)
            st_fetch: begin
                ir_en     = 1'b1;
                old_pc_en = 1'b1;
                pc_en     = 1'b1;
                alu_src_a = src_a_pc;
                alu_src_b = src_b_four;
                alu_op    = alu_add;
            end
            st_decode: begin // target for branch, jal and auipc
                alu_src_a = src_a_old_pc;
                alu_src_b = src_b_imm;
                alu_op    = alu_add;
                case (opcode)
                    op_branch: imm_src = imm_b;
                    op_jal:    imm_src = imm_j;
                    op_auipc:  imm_src = imm_u;
                    default:   imm_src = imm_none;
                endcase
            end
            st_mem_addr: begin
                alu_src_a = src_a_reg1;
                alu_src_b = src_b_imm;
                alu_op    = alu_add;
                imm_src   = (opcode == op_load) ? imm_i : imm_s;
            end
            st_mem_read: begin
                addr_src = 1'b1;
                data_en  = 1'b1;
                dt       = mem_dt;
            end
            st_mem_write: begin
                addr_src = 1'b1;
                mem_we   = 1'b1;
                dt       = mem_dt;
            end
            st_mem_wb: begin
                rf_we   = 1'b1;
                res_src = res_load;
            end
            st_exec_r: begin
                alu_src_a = src_a_reg1;
                alu_src_b = src_b_reg2;
                alu_op    = alu_dec;
            end
            st_exec_i: begin
                alu_src_a = src_a_reg1;
                alu_src_b = src_b_imm;
                alu_op    = alu_dec;
                imm_src   = (funct3[1:0] == 2'b01) ? imm_i_shift : imm_i;
            end
            st_alu_wb, st_exec_auipc: rf_we = 1'b1;
            st_branch: begin
                alu_src_a = src_a_reg1;
                alu_src_b = src_b_reg2;
                alu_op    = alu_sub;
                pc_en     = take_branch;
            end
            st_exec_jal: begin
                pc_en     = 1'b1;
                rf_we     = 1'b1;
                rf_wd_src = wd_link;
            end
            st_exec_jalr: begin
                alu_src_a = src_a_reg1;
                alu_src_b = src_b_imm;
                alu_op    = alu_add;
                imm_src   = imm_i;
                rf_we     = 1'b1;
                rf_wd_src = wd_link;
            end
            st_jalr_pc: pc_en = 1'b1;
            st_exec_lui: begin
                rf_we   = 1'b1;
                res_src = res_imm;
                imm_src = imm_u;
            end
            default: ; // error state drives nothing
        endcase
    end

endmodule

//--- rtl/rv_datapath.sv
`timescale 1ns/1ps

module rv_datapath import rv_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        rf_we,
    input  logic        mem_we,
    input  logic        ir_en,
    input  logic        pc_en,
    input  logic        old_pc_en,
    input  logic        addr_src,
    input  logic        data_en,
    input  alu_src_a_e  alu_src_a,
    input  alu_src_b_e  alu_src_b,
    input  alu_op_e     alu_op,
    input  imm_src_e    imm_src,
    input  mem_dt_e     dt,
    input  res_src_e    res_src,
    input  rf_wd_src_e  rf_wd_src,
    output logic [31:0] instr,
    output alu_flags_t  alu_flags,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic [3:0]  mem_be,
    input  logic [31:0] mem_rdata
);
    logic [xlen-1:0] pc, old_pc, ir, data_q, alu_out;
    logic [xlen-1:0] reg1, reg2, rd1, rd2;
    logic [xlen-1:0] imm, src_a, src_b, alu_y;
    logic [xlen-1:0] result, rf_wd, load_data;
    logic [3:0]      lsu_be;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (pc_en) begin
            // fetch takes pc+4 straight from the alu
            pc <= ir_en ? alu_y : {alu_out[xlen-1:1], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (ir_en) ir <= mem_rdata;
        if (old_pc_en) old_pc <= pc;
        if (data_en) data_q <= load_data;
        reg1    <= rd1;
        reg2    <= rd2;
        alu_out <= alu_y;
    end

    always_comb begin
        case (alu_src_a)
            src_a_pc:     src_a = pc;
            src_a_old_pc: src_a = old_pc;
            src_a_reg1:   src_a = reg1;
            default:      src_a = '0;
        endcase
        case (alu_src_b)
            src_b_four: src_b = 32'd4;
            src_b_imm:  src_b = imm;
            src_b_reg2: src_b = reg2;
            default:    src_b = '0;
        endcase
        case (res_src)
            res_load: result = data_q;
            res_imm:  result = imm;
            default:  result = alu_out;
        endcase
    end

    assign rf_wd    = (rf_wd_src == wd_link) ? old_pc + 32'd4 : result;
    assign instr    = ir;
    assign mem_addr = addr_src ? alu_out : pc;
    assign mem_be   = mem_we ? lsu_be : 4'b0000; // lanes only on writes

    rv_regfile i_regfile (
        .clk(clk), .rst(rst),
        .ra1(ir[19:15]), .ra2(ir[24:20]), .wa(ir[11:7]),
        .we(rf_we), .wd(rf_wd), .rd1(rd1), .rd2(rd2)
    );

    rv_imm_ext i_imm_ext (.instr(ir), .imm_src(imm_src), .imm(imm));

    rv_alu i_alu (.a(src_a), .b(src_b), .op(alu_op), .y(alu_y), .flags(alu_flags));

    rv_lsu i_lsu (
        .addr_lo(alu_out[1:0]), .dt(dt), .store_data(reg2), .rdata(mem_rdata),
        .wdata(mem_wdata), .be(lsu_be), .load_data(load_data)
    );

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
    parameter logic [31:0] reset_pc = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic [3:0]  mem_be,
    output logic        mem_we,
    output logic        halted,
    input  logic [31:0] mem_rdata
);
    logic [31:0] instr;
    alu_flags_t  alu_flags;
    logic        rf_we, ir_en, pc_en, old_pc_en, addr_src, data_en;
    alu_src_a_e  alu_src_a;
    alu_src_b_e  alu_src_b;
    alu_op_e     alu_op;
    imm_src_e    imm_src;
    mem_dt_e     dt;
    res_src_e    res_src;
    rf_wd_src_e  rf_wd_src;

    rv_controller i_controller (
        .clk(clk), .rst(rst), .instr(instr), .alu_flags(alu_flags),
        .rf_we(rf_we), .mem_we(mem_we), .ir_en(ir_en), .pc_en(pc_en),
        .old_pc_en(old_pc_en), .addr_src(addr_src), .data_en(data_en), .halted(halted),
        .alu_src_a(alu_src_a), .alu_src_b(alu_src_b), .alu_op(alu_op),
        .imm_src(imm_src), .dt(dt), .res_src(res_src), .rf_wd_src(rf_wd_src)
    );

    rv_datapath #(.reset_pc(reset_pc)) i_datapath (
        .clk(clk), .rst(rst),
        .rf_we(rf_we), .mem_we(mem_we), .ir_en(ir_en), .pc_en(pc_en),
        .old_pc_en(old_pc_en), .addr_src(addr_src), .data_en(data_en),
        .alu_src_a(alu_src_a), .alu_src_b(alu_src_b), .alu_op(alu_op),
        .imm_src(imm_src), .dt(dt), .res_src(res_src), .rf_wd_src(rf_wd_src),
        .instr(instr), .alu_flags(alu_flags),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_be(mem_be), .mem_rdata(mem_rdata)
    );

endmodule

//--- bench/rv_core_sva.sv
`timescale 1ns/1ps

module rv_core_sva (
    input logic       clk,
    input logic       rst,
    input logic       mem_we,
    input logic [3:0] mem_be,
    input logic       halted
);

    a_no_write_in_reset: assert property (@(posedge clk) rst |-> !mem_we)
        else $error("mem_we high during reset");

    a_no_write_halted: assert property (@(posedge clk) disable iff (rst) halted |-> !mem_we)
        else $error("mem_we high while halted");

    a_be_on_write: assert property (@(posedge clk) disable iff (rst) mem_we |-> mem_be != 4'b0000)
        else $error("mem_we high with no byte enabled");

    a_write_one_cycle: assert property (@(posedge clk) disable iff (rst) mem_we |=> !mem_we)
        else $error("mem_we held for more than one cycle");

    // only reset clears the error state
    a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else $error("halted dropped without reset");

endmodule

bind rv_core rv_core_sva i_rv_core_sva (
    .clk(clk),
    .rst(rst),
    .mem_we(mem_we),
    .mem_be(mem_be),
    .halted(halted)
);

//--- bench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

    localparam logic [31:0] reset_pc = 32'h0;
    localparam int clk_period   = 40;
    localparam int reset_cycles = 8;
    localparam int num_progs    = 6;
    localparam int max_instrs   = 60;
    // at most 5 cycles per instruction, plus the stop word and reset per program
    localparam int watchdog_ns  =
        num_progs * ((max_instrs + 1) * 5 + reset_cycles + 8) * clk_period;

    logic        clk;
    logic        rst;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic [3:0]  mem_be;
    logic        mem_we;
    logic        halted;

    logic [31:0] mem [1024];
    logic [31:0] model_mem [1024];
    logic [31:0] lfsr_q;
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [3:0]  exp_be_q [$];
    logic [31:0] stop_addr;
    int          model_writes;
    int          dut_writes;
    int          prog_idx;
    int          value_errors;
    int          other_errors;

    rv_core #(.reset_pc(reset_pc)) i_rv_core (
        .clk(clk), .rst(rst), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_be(mem_be), .mem_we(mem_we), .halted(halted), .mem_rdata(mem_rdata)
    );

    assign mem_rdata = mem[mem_addr[11:2]]; // same-cycle read

    always @(posedge clk) begin
        if (mem_we) begin
            for (int l = 0; l < 4; l++) begin
                if (mem_be[l]) mem[mem_addr[11:2]][8*l +: 8] <= mem_wdata[8*l +: 8];
            end
        end
    end

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_be(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("Error %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("Error %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Failure in program %0d: %s", prog_idx, what);
    endtask

    // checks every write mid-cycle, where the bus is settled
    always @(negedge clk) begin
        if (mem_we) begin
            dut_writes++;
            if (halted) begin
                report_failure("store after halt");
            end else if (exp_addr_q.size() == 0) begin
                report_failure("more stores than expected");
            end else begin
                compare_word($sformatf("prog %0d store addr", prog_idx),
                             exp_addr_q.pop_front(), mem_addr);
                compare_word($sformatf("prog %0d store data", prog_idx),
                             exp_data_q.pop_front(), mem_wdata);
                compare_be($sformatf("prog %0d store be", prog_idx),
                           exp_be_q.pop_front(), mem_be);
            end
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'd0, $signed(a) < $signed(b)};
            3'd3: r = {31'd0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) r = $signed(a) >>> b[4:0];
                else r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic build_program(output int n);
        int          base;
        int          k;
        int          cls;
        int          f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [9:0]  off;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [19:0] upper;
        logic [6:0]  f7;
        logic [31:0] ins;
        n = 40 + int'(take_bits(5) % 21);
        base = int'(reset_pc[11:2]);
        for (int i = 0; i < 1024; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 256; i < 512; i++) begin
            model_mem[i] = take_bits(32); // data region 0x400-0x7ff
        end
        for (int i = 0; i < n; i++) begin
            cls   = int'(take_bits(4));
            rd    = take_bits(4);
            rs1   = take_bits(4);
            rs2   = take_bits(4);
            f3    = int'(take_bits(3));
            off   = take_bits(10);
            upper = take_bits(20);
            k     = 1 + int'(take_bits(2));
            if (k > n - i) k = n - i; // forward, at most to the stop word
            case (cls)
                0, 1, 2: begin
                    f7 = ((f3 == 0 || f3 == 5) && take_bits(1)) ? 7'b0100000 : 7'b0;
                    ins = {f7, rs2, rs1, f3[2:0], rd, op_r_type};
                end
                3, 4, 5: begin
                    imm = take_bits(12);
                    if (f3 == 1) imm = {7'b0, imm[4:0]};
                    if (f3 == 5) imm = {1'b0, imm[10], 5'b0, imm[4:0]}; // srli or srai
                    ins = {imm, rs1, f3[2:0], rd, op_i_type};
                end
                6: ins = {upper, rd, op_lui};
                7: ins = {upper, rd, op_auipc};
                8: begin
                    if (f3 == 3 || f3 > 5) f3 = f3 & 5;
                    if (f3[1:0] == 2'd1) off[0] = 1'b0;
                    if (f3[1:0] == 2'd2) off[1:0] = 2'b00;
                    imm = {2'b01, off};
                    ins = {imm, 5'd0, f3[2:0], rd, op_load};
                end
                9, 10, 11: begin
                    f3 = f3 % 3;
                    if (f3 == 1) off[0] = 1'b0;
                    if (f3 == 2) off[1:0] = 2'b00;
                    imm = {2'b01, off};
                    ins = {imm[11:5], rs2, 5'd0, f3[2:0], imm[4:0], op_store};
                end
                12, 13: begin
                    if (f3 == 2 || f3 == 3) f3 = f3 + 2;
                    rs1 = rs1 & 5'd7; // small register set so equal operands happen
                    rs2 = rs2 & 5'd7;
                    boff = 13'(4 * k);
                    ins = {boff[12], boff[10:5], rs2, rs1, f3[2:0], boff[4:1], boff[11],
                           op_branch};
                end
                14: begin
                    joff = 21'(4 * k);
                    ins = {joff[20], joff[10:1], joff[11], joff[19:12], rd, op_jal};
                end
                default: begin
                    imm = 12'(int'(reset_pc) + 4 * (i + k)) | 12'(take_bits(1));
                    ins = {imm, 5'd0, 3'b000, rd, op_jalr};
                end
            endcase
            model_mem[base + i] = ins;
        end
    endtask

    task automatic run_model();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] t;
        logic [31:0] addr;
        logic [31:0] lane;
        logic [31:0] data;
        logic [3:0]  be;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        taken;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = reset_pc;
        stop_addr = 32'hffff_ffff;
        model_writes = 0;
        for (int step = 0; step <= max_instrs + 1; step++) begin
            ins = model_mem[pc[11:2]];
            rd  = ins[11:7];
            f3  = ins[14:12];
            a   = x[ins[19:15]];
            b   = x[ins[24:20]];
            case (ins[6:0])
                op_r_type: begin
                    x[rd] = alu_model(f3, ins[30], a, b);
                    pc = pc + 4;
                end
                op_i_type: begin
                    t = (f3 == 1 || f3 == 5) ? {27'd0, ins[24:20]} : sext12(ins[31:20]);
                    x[rd] = alu_model(f3, (f3 == 5) && ins[30], a, t);
                    pc = pc + 4;
                end
                op_load: begin
                    addr = a + sext12(ins[31:20]);
                    lane = model_mem[addr[11:2]] >> (8 * addr[1:0]);
                    case (f3)
                        3'd0: x[rd] = {{24{lane[7]}}, lane[7:0]};
                        3'd1: x[rd] = {{16{lane[15]}}, lane[15:0]};
                        3'd4: x[rd] = {24'd0, lane[7:0]};
                        3'd5: x[rd] = {16'd0, lane[15:0]};
                        default: x[rd] = lane;
                    endcase
                    pc = pc + 4;
                end
                op_store: begin
                    addr = a + sext12({ins[31:25], ins[11:7]});
                    data = (f3 == 0) ? {4{b[7:0]}} : (f3 == 1) ? {2{b[15:0]}} : b;
                    be = (f3 == 0) ? 4'b0001 << addr[1:0] :
                         (f3 == 1) ? (addr[1] ? 4'b1100 : 4'b0011) : 4'b1111;
                    for (int l = 0; l < 4; l++) begin
                        if (be[l]) model_mem[addr[11:2]][8*l +: 8] = data[8*l +: 8];
                    end
                    exp_addr_q.push_back(addr);
                    exp_data_q.push_back(data);
                    exp_be_q.push_back(be);
                    model_writes++;
                    pc = pc + 4;
                end
                op_branch: begin
                    case (f3)
                        3'd0: taken = (a == b);
                        3'd1: taken = (a != b);
                        3'd4: taken = ($signed(a) < $signed(b));
                        3'd5: taken = ($signed(a) >= $signed(b));
                        3'd6: taken = (a < b);
                        default: taken = (a >= b);
                    endcase
                    t = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    pc = taken ? pc + t : pc + 4;
                end
                op_jal: begin
                    x[rd] = pc + 4;
                    pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                op_jalr: begin
                    t = (a + sext12(ins[31:20])) & ~32'd1;
                    x[rd] = pc + 4;
                    pc = t;
                end
                op_lui: begin
                    x[rd] = {ins[31:12], 12'd0};
                    pc = pc + 4;
                end
                op_auipc: begin
                    x[rd] = pc + {ins[31:12], 12'd0};
                    pc = pc + 4;
                end
                default: begin
                    stop_addr = pc;
                    break;
                end
            endcase
            x[0] = '0;
        end
    endtask

    task automatic run_program(input int p);
        int n;
        @(posedge clk);
        #1;
        rst = 1'b1;
        prog_idx = p;
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_be_q.delete();
        dut_writes = 0;
        build_program(n);
        for (int i = 0; i < 1024; i++) begin
            mem[i] <= model_mem[i];
        end
        run_model();
        repeat (reset_cycles) begin
            @(negedge clk);
            compare_flag($sformatf("prog %0d mem_we in reset", p), 1'b0, mem_we);
            compare_flag($sformatf("prog %0d halted in reset", p), 1'b0, halted);
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        compare_word($sformatf("prog %0d first fetch", p), reset_pc, mem_addr);
        while (!halted) @(negedge clk);
        repeat (4) @(negedge clk); // no writes may follow the halt
        compare_flag($sformatf("prog %0d halted", p), 1'b1, halted);
        compare_word($sformatf("prog %0d halt pc", p), stop_addr + 32'd4, mem_addr);
        compare_word($sformatf("prog %0d write count", p), 32'(model_writes), 32'(dut_writes));
        if (exp_addr_q.size() != 0) report_failure("fewer stores than expected");
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        lfsr_q = 32'h196e654c;
        value_errors = 0;
        other_errors = 0;
        dut_writes = 0;
        prog_idx = 0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] <= '0;
        end
        for (int p = 0; p < num_progs; p++) begin
            run_program(p);
        end
        $display("Checks finished with %0d value errors and %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before all programs reached their stop word");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- sources.f
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_imm_ext.sv
rtl/rv_lsu.sv
rtl/rv_controller.sv
rtl/rv_datapath.sv
rtl/rv_core.sv
bench/rv_core_sva.sv
bench/rv_core_tb.sv
